// File: rtl/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath and field widths
`define DEC_XLEN  32
`define DEC_REG_W 5
`define DEC_OPC_W 5
`define DEC_EXC_W 8

// opcode map anchors
`define DEC_OPC_ALU_REG       5'd0
`define DEC_OPC_ALU_IMM       5'd1
`define DEC_OPC_LUI           5'd2
`define DEC_OPC_JMP           5'd12
`define DEC_OPC_SYSCALL       5'd15
`define DEC_OPC_FADD_FIRST    5'd16
`define DEC_OPC_SWAP_FIRST    5'd19
`define DEC_OPC_INVALID_FIRST 5'd23
`define DEC_OPC_INVALID_LAST  5'd30
`define DEC_OPC_PRIV          5'd31

// alu op used by the fetch-add middle step
`define DEC_ALU_ADD 5'd14

`define DEC_EXC_INVALID 8'h80
`define DEC_EXC_PRIV    8'h81

`endif

// File: rtl/decode_pkg.sv
`default_nettype none
`include "decode_params.svh"

package decode_pkg;

  // normal layout keeps the register fields directly below the opcode
  typedef struct packed {
    logic [`DEC_OPC_W-1:0]                                  opcode;
    logic [`DEC_REG_W-1:0]                                  r_a;
    logic [`DEC_REG_W-1:0]                                  r_b;
    logic [`DEC_XLEN-`DEC_OPC_W-2*`DEC_REG_W-1:0]           payload;
  } instr_norm_t;

  // branch layout puts the condition code up top and the registers in the low bits
  typedef struct packed {
    logic [`DEC_OPC_W-1:0]                                  opcode;
    logic [`DEC_REG_W-1:0]                                  branch_code;
    logic [`DEC_XLEN-`DEC_OPC_W-3*`DEC_REG_W-1:0]           offset;
    logic [`DEC_REG_W-1:0]                                  r_a;
    logic [`DEC_REG_W-1:0]                                  r_b;
  } instr_br_t;

  // the opcode selects which layout a fetched word is read through
  typedef union packed {
    instr_norm_t norm;
    instr_br_t   br;
  } instr_t;

  // position of a micro-op inside a cracked atomic
  typedef logic [1:0] uop_step_t;

endpackage

`default_nettype wire

// File: rtl/instr_classify.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module instr_classify (
  input  wire decode_pkg::instr_t     cur_instr,
  input  wire                         kmode,
  input  wire                         inflight,
  output logic                        is_mem,
  output logic                        is_branch_op,
  output logic                        is_priv,
  output logic [`DEC_EXC_W-1:0]       exc_code
);

  logic [`DEC_OPC_W-1:0] opcode;
  logic [16:0]           payload;
  logic [`DEC_REG_W-1:0] alu_op;
  logic                  is_syscall;
  logic                  opc_invalid;
  logic                  bad_alu;
  logic                  bad_branch;
  logic                  bad_syscall;
  logic                  bad_priv;
  logic                  invalid_instr;
  logic                  priv_in_user;

  assign opcode  = cur_instr.norm.opcode;
  assign payload = cur_instr.norm.payload;

  // register form keeps the alu op lower in the word than the immediate form
  assign alu_op = (opcode == `DEC_OPC_ALU_REG) ? payload[9:5] : payload[16:12];

  // memory sits between lui and jmp, branches between jmp and syscall
  // a cracked slot always counts as memory class
  assign is_mem = inflight ||
    ((opcode > `DEC_OPC_LUI) && (opcode < `DEC_OPC_JMP));
  assign is_branch_op = (opcode >= `DEC_OPC_JMP) && (opcode < `DEC_OPC_SYSCALL);
  assign is_syscall   = (opcode == `DEC_OPC_SYSCALL);
  assign is_priv      = (opcode == `DEC_OPC_PRIV);
  assign opc_invalid  = (opcode >= `DEC_OPC_INVALID_FIRST) &&
                        (opcode <= `DEC_OPC_INVALID_LAST);

  assign bad_alu =
    ((opcode == `DEC_OPC_ALU_IMM) && (alu_op > 5'd18)) ||
    ((opcode == `DEC_OPC_ALU_REG) && (alu_op > 5'd22));
  assign bad_branch  = is_branch_op && (cur_instr.br.branch_code > 5'd18);
  // only syscall code 1 is defined
  assign bad_syscall = is_syscall && (payload[7:0] != 8'd1);
  // privileged type lives where the immediate-form alu op would be
  assign bad_priv    = is_priv && (payload[16:12] > 5'd4);

  assign invalid_instr = opc_invalid || bad_alu || bad_branch || bad_syscall || bad_priv;
  assign priv_in_user  = is_priv && !kmode;

  // micro-ops of a crack come from a word that already passed decode checks
  always_comb begin
    if (inflight) begin
      exc_code = '0;
    end else if (invalid_instr) begin
      exc_code = `DEC_EXC_INVALID;
    end else if (priv_in_user) begin
      exc_code = `DEC_EXC_PRIV;
    end else if (is_syscall) begin
      exc_code = payload[7:0];
    end else begin
      exc_code = '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module operand_select (
  input  wire decode_pkg::instr_t     cur_instr,
  input  wire                         inflight,
  input  wire                         fetch_add_mode,
  input  wire decode_pkg::uop_step_t  step,
  output logic [`DEC_OPC_W-1:0]       opcode_eff,
  output logic [`DEC_REG_W-1:0]       alu_op_eff,
  output logic [`DEC_REG_W-1:0]       src_1,
  output logic [`DEC_REG_W-1:0]       src_2,
  output logic [`DEC_REG_W-1:0]       dst_1,
  output logic [`DEC_REG_W-1:0]       dst_2,
  output logic [`DEC_XLEN-1:0]        imm,
  output logic                        mem_load,
  output logic                        mem_store,
  output logic                        post_inc
);

  logic [`DEC_OPC_W-1:0] opcode;
  logic [16:0]           p;
  logic [`DEC_REG_W-1:0] rb_raw;
  logic                  br_fmt;
  logic [`DEC_REG_W-1:0] r_a;
  logic [`DEC_REG_W-1:0] r_b;
  logic [`DEC_REG_W-1:0] alu_op;
  logic                  is_abs;
  logic                  is_rel;
  logic                  is_immf;
  logic                  load_bit;
  logic [1:0]            inc_type;
  logic [`DEC_XLEN-1:0]  sext12;
  logic [`DEC_XLEN-1:0]  sext22;
  logic [`DEC_XLEN-1:0]  base_imm;
  logic                  no_src_1;
  logic                  alias_load;
  logic [`DEC_OPC_W-1:0] crack_form;
  logic [`DEC_REG_W-1:0] crack_base;
  logic                  crack_load;
  logic                  crack_add;
  logic                  crack_store;

  assign opcode = cur_instr.norm.opcode;
  assign p      = cur_instr.norm.payload;
  assign rb_raw = cur_instr.norm.r_b;

  // conditional branches (13, 14) move both registers into the low bits
  assign br_fmt = (opcode > `DEC_OPC_JMP) && (opcode < `DEC_OPC_SYSCALL);
  assign r_a    = br_fmt ? cur_instr.br.r_a : cur_instr.norm.r_a;
  assign r_b    = br_fmt ? cur_instr.br.r_b : cur_instr.norm.r_b;
  assign alu_op = (opcode == `DEC_OPC_ALU_REG) ? p[9:5] : p[16:12];

  // absolute memory forms are 3/6/9, relative 4/7/10 and immediate 5/8/11
  assign is_abs  = (opcode == 5'd3) || (opcode == 5'd6) || (opcode == 5'd9);
  assign is_rel  = (opcode == 5'd4) || (opcode == 5'd7) || (opcode == 5'd10);
  assign is_immf = (opcode == 5'd5) || (opcode == 5'd8) || (opcode == 5'd11);
  // immediate form has no room at bit 16, so the direction bit moves to 21
  assign load_bit = is_immf ? rb_raw[4] : p[16];
  // 0 offset, 1 pre-increment, 2 post-increment
  assign inc_type = p[15:14];

  assign sext12 = {{20{p[11]}}, p[11:0]};
  assign sext22 = {{10{rb_raw[4]}}, rb_raw, p};

  always_comb begin
    base_imm = '0;
    if (opcode == `DEC_OPC_ALU_IMM) begin
      // bitwise ops place a byte at a shifted lane, shifts take 5 bits
      if (alu_op <= 5'd6)
        base_imm = {24'd0, p[7:0]} << {p[9:8], 3'd0};
      else if (alu_op <= 5'd13)
        base_imm = {27'd0, p[4:0]};
      else
        base_imm = sext12;
    end else if (opcode == `DEC_OPC_LUI) begin
      base_imm = {rb_raw, p, 10'd0};
    end else if ((opcode == `DEC_OPC_JMP) || (opcode == 5'd22)) begin
      base_imm = sext22;
    end else if (is_abs) begin
      base_imm = sext12 << p[13:12];
    end else if (is_rel) begin
      base_imm = {{16{p[15]}}, p[15:0]};
    end else if (is_immf) begin
      base_imm = {{11{rb_raw[3]}}, rb_raw[3:0], p};
    end
  end

  // lui, pc-relative memory, jmp, syscall and alu op 6 never read r_b
  assign no_src_1 = (opcode == `DEC_OPC_LUI) || is_immf || (opcode == `DEC_OPC_JMP) ||
    (opcode == `DEC_OPC_SYSCALL) ||
    (((opcode == `DEC_OPC_ALU_REG) || (opcode == `DEC_OPC_ALU_IMM)) && (alu_op == 5'd6));

  assign post_inc = !inflight && is_abs && (inc_type == 2'd2);
  // post-increment load into its own base keeps only the base update
  assign alias_load = post_inc && load_bit && (r_a == r_b);

  // each atomic family comes as absolute, relative, immediate
  assign crack_form = fetch_add_mode ? (opcode - `DEC_OPC_FADD_FIRST) :
                                       (opcode - `DEC_OPC_SWAP_FIRST);
  assign crack_base  = (crack_form == 5'd2) ? '0 : p[16:12];
  assign crack_load  = (step == 2'd0);
  assign crack_add   = fetch_add_mode && (step == 2'd1);
  assign crack_store = fetch_add_mode ? (step == 2'd2) : (step == 2'd1);

  always_comb begin
    if (inflight) begin
      opcode_eff = crack_add ? `DEC_OPC_ALU_REG : (5'd3 + crack_form);
      alu_op_eff = crack_add ? `DEC_ALU_ADD : '0;
      // r_b of the atomic word carries the data register
      src_1      = crack_add ? rb_raw : crack_base;
      src_2      = (fetch_add_mode && !crack_load) ? r_a : rb_raw;
      dst_1      = r_a;
      imm        = crack_add ? '0 :
                   (crack_form == 5'd2) ? {{15{p[16]}}, p} : sext12;
      mem_load   = crack_load;
      mem_store  = crack_store;
    end else begin
      opcode_eff = opcode;
      alu_op_eff = alu_op;
      src_1      = no_src_1 ? '0 : r_b;
      // stores and privileged ops read r_a, only alu-reg reads r_c
      src_2      = ((is_abs || is_rel || is_immf) && !load_bit) ||
                   (opcode == `DEC_OPC_PRIV) ? r_a :
                   (opcode == `DEC_OPC_ALU_REG) ? p[4:0] : '0;
      dst_1      = ((opcode == `DEC_OPC_JMP) || (opcode == `DEC_OPC_SYSCALL) || alias_load) ?
                   '0 : r_a;
      imm        = base_imm;
      mem_load   = load_bit;
      mem_store  = !load_bit;
    end
  end

  // base write-back for pre and post increment
  assign dst_2 = (!inflight && is_abs && (inc_type != 2'd0)) ? r_b : '0;

endmodule

`default_nettype wire

// File: rtl/atomic_cracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module atomic_cracker (
  input  wire                         clk,
  input  wire                         rst,
  input  wire decode_pkg::instr_t     front_instr,
  input  wire                         stall,
  input  wire                         cancel,
  output decode_pkg::instr_t          cur_instr,
  output logic                        inflight,
  output logic                        fetch_add_mode,
  output decode_pkg::uop_step_t       step
);

  logic [`DEC_OPC_W-1:0] front_opc;
  logic                  front_fa;
  logic                  front_swap;
  logic                  start;
  logic                  last;
  logic                  active;
  logic                  fa_q;
  decode_pkg::uop_step_t step_q;
  decode_pkg::instr_t    held;

  assign front_opc  = front_instr.norm.opcode;
  assign front_fa   = (front_opc >= `DEC_OPC_FADD_FIRST) &&
                      (front_opc < `DEC_OPC_SWAP_FIRST);
  assign front_swap = (front_opc >= `DEC_OPC_SWAP_FIRST) &&
                      (front_opc < `DEC_OPC_SWAP_FIRST + 5'd3);

  // first micro-op is decoded straight from the frontend word
  assign start = !active && !cancel && (front_fa || front_swap);
  assign last  = fa_q ? (step_q == 2'd2) : (step_q == 2'd1);

  assign inflight       = active || start;
  assign cur_instr      = active ? held : front_instr;
  assign fetch_add_mode = active ? fa_q : front_fa;
  assign step           = active ? step_q : 2'd0;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      fa_q   <= 1'b0;
      step_q <= 2'd0;
    end else if (!stall) begin
      if (cancel) begin
        active <= 1'b0;
        step_q <= 2'd0;
      end else if (start) begin
        active <= 1'b1;
        fa_q   <= front_fa;
        step_q <= 2'd1;
      end else if (active) begin
        if (last) begin
          active <= 1'b0;
          step_q <= 2'd0;
        end else begin
          step_q <= step_q + 2'd1;
        end
      end
    end
  end

  // word stays parked here for the remaining micro-ops
  always_ff @(posedge clk) begin
    if (!stall && start) begin
      held <= front_instr;
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module decode_stage (
  input  wire                         clk,
  input  wire                         rst,
  input  wire [`DEC_XLEN-1:0]         instr,
  input  wire [`DEC_XLEN-1:0]         pc,
  input  wire                         bubble_in,
  input  wire [`DEC_EXC_W-1:0]        exc_in,
  input  wire                         stall,
  input  wire                         flush,
  input  wire                         kmode,
  output logic [`DEC_OPC_W-1:0]       opcode_out,
  output logic [`DEC_REG_W-1:0]       alu_op_out,
  output logic [`DEC_REG_W-1:0]       s_1,
  output logic [`DEC_REG_W-1:0]       s_2,
  output logic [`DEC_REG_W-1:0]       tgt_1,
  output logic [`DEC_REG_W-1:0]       tgt_2,
  output logic [`DEC_XLEN-1:0]        imm_out,
  output logic [`DEC_REG_W-1:0]       branch_code_out,
  output logic [`DEC_XLEN-1:0]        pc_out,
  output logic                        is_load,
  output logic                        is_store,
  output logic                        is_branch,
  output logic                        is_post_inc,
  output logic                        is_atomic,
  output decode_pkg::uop_step_t       atomic_step,
  output logic [`DEC_EXC_W-1:0]       exc_out,
  output logic                        bubble_out,
  output logic                        decode_stall
);

  decode_pkg::instr_t    cur_instr;
  decode_pkg::uop_step_t step;
  logic                  inflight;
  logic                  fetch_add_mode;
  logic                  cancel;
  logic                  is_mem;
  logic                  is_branch_op;
  logic                  is_priv;
  logic [`DEC_EXC_W-1:0] exc_code;
  logic [`DEC_OPC_W-1:0] opcode_eff;
  logic [`DEC_REG_W-1:0] alu_op_eff;
  logic [`DEC_REG_W-1:0] src_1;
  logic [`DEC_REG_W-1:0] src_2;
  logic [`DEC_REG_W-1:0] dst_1;
  logic [`DEC_REG_W-1:0] dst_2;
  logic [`DEC_XLEN-1:0]  imm;
  logic                  mem_load;
  logic                  mem_store;
  logic                  post_inc;
  logic [`DEC_EXC_W-1:0] slot_exc;
  logic                  slot_kill;
  logic                  load_d;
  logic                  store_d;

  // redirects and incoming bubbles kill the slot and any crack
  assign cancel = flush || bubble_in;

  atomic_cracker atomic_cracker_inst (
    .clk            (clk),
    .rst            (rst),
    .front_instr    (instr),
    .stall          (stall),
    .cancel         (cancel),
    .cur_instr      (cur_instr),
    .inflight       (inflight),
    .fetch_add_mode (fetch_add_mode),
    .step           (step)
  );

  instr_classify instr_classify_inst (
    .cur_instr    (cur_instr),
    .kmode        (kmode),
    .inflight     (inflight),
    .is_mem       (is_mem),
    .is_branch_op (is_branch_op),
    .is_priv      (is_priv),
    .exc_code     (exc_code)
  );

  operand_select operand_select_inst (
    .cur_instr      (cur_instr),
    .inflight       (inflight),
    .fetch_add_mode (fetch_add_mode),
    .step           (step),
    .opcode_eff     (opcode_eff),
    .alu_op_eff     (alu_op_eff),
    .src_1          (src_1),
    .src_2          (src_2),
    .dst_1          (dst_1),
    .dst_2          (dst_2),
    .imm            (imm),
    .mem_load       (mem_load),
    .mem_store      (mem_store),
    .post_inc       (post_inc)
  );

  assign decode_stall = inflight;

  // frontend fault wins over anything found here
  assign slot_exc  = (exc_in != '0) ? exc_in : exc_code;
  assign slot_kill = cancel || (slot_exc != '0);
  assign load_d    = is_mem && mem_load;
  assign store_d   = is_mem && mem_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      bubble_out  <= 1'b1;
      exc_out     <= '0;
      is_load     <= 1'b0;
      is_store    <= 1'b0;
      is_branch   <= 1'b0;
      is_post_inc <= 1'b0;
      is_atomic   <= 1'b0;
      atomic_step <= 2'd0;
      tgt_1       <= '0;
      tgt_2       <= '0;
    end else if (!stall) begin
      // a faulting slot stays live so the trap reaches write-back
      bubble_out  <= cancel;
      exc_out     <= cancel ? '0 : slot_exc;
      is_load     <= !slot_kill && load_d;
      is_store    <= !slot_kill && store_d;
      is_branch   <= !slot_kill && is_branch_op;
      is_post_inc <= !slot_kill && post_inc;
      is_atomic   <= !slot_kill && inflight;
      atomic_step <= slot_kill ? 2'd0 : step;
      // stores and privileged ops write no gpr
      tgt_1       <= (slot_kill || store_d || is_priv) ? '0 : dst_1;
      tgt_2       <= slot_kill ? '0 : dst_2;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      opcode_out      <= slot_kill ? '0 : opcode_eff;
      alu_op_out      <= slot_kill ? '0 : alu_op_eff;
      s_1             <= slot_kill ? '0 : src_1;
      s_2             <= slot_kill ? '0 : src_2;
      imm_out         <= slot_kill ? '0 : imm;
      branch_code_out <= slot_kill ? '0 : cur_instr.br.branch_code;
      pc_out          <= pc;
    end
  end

endmodule

`default_nettype wire

// File: test/decode_stage_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module decode_stage_props (
  input wire                  clk,
  input wire                  rst,
  input wire [`DEC_XLEN-1:0]  instr,
  input wire                  bubble_in,
  input wire [`DEC_EXC_W-1:0] exc_in,
  input wire                  stall,
  input wire                  flush,
  input wire                  kmode,
  input wire [`DEC_OPC_W-1:0] opcode_out,
  input wire [`DEC_REG_W-1:0] alu_op_out,
  input wire [`DEC_REG_W-1:0] s_1,
  input wire [`DEC_REG_W-1:0] s_2,
  input wire [`DEC_REG_W-1:0] tgt_1,
  input wire [`DEC_REG_W-1:0] tgt_2,
  input wire [`DEC_REG_W-1:0] branch_code_out,
  input wire [`DEC_XLEN-1:0]  imm_out,
  input wire [`DEC_XLEN-1:0]  pc_out,
  input wire                  is_load,
  input wire                  is_store,
  input wire                  is_branch,
  input wire                  is_post_inc,
  input wire                  is_atomic,
  input wire [1:0]            atomic_step,
  input wire [`DEC_EXC_W-1:0] exc_out,
  input wire                  bubble_out,
  input wire                  decode_stall
);

  logic [`DEC_OPC_W-1:0] opc;
  logic [`DEC_REG_W-1:0] aop;
  logic                  quiet;
  logic                  fa_word;
  logic                  sw_word;
  logic                  plain;
  logic                  prev_atomic;
  logic                  new_fa;
  logic                  new_sw;
  logic [`DEC_XLEN-1:0]  exp_bitwise;
  logic [`DEC_XLEN-1:0]  exp_arith;
  logic [114:0]          slot;
  int                    fail_count = 0;

  assign opc     = instr[31:27];
  assign aop     = instr[16:12];
  assign quiet   = !rst && !stall && !flush && !bubble_in && (exc_in == 8'd0);
  assign fa_word = (opc >= `DEC_OPC_FADD_FIRST) && (opc < `DEC_OPC_SWAP_FIRST);
  assign sw_word = (opc >= `DEC_OPC_SWAP_FIRST) && (opc < `DEC_OPC_SWAP_FIRST + 5'd3);
  // a non-atomic word on the input means no crack is in flight
  assign plain   = quiet && !fa_word && !sw_word;
  assign new_fa  = quiet && fa_word && !prev_atomic;
  assign new_sw  = quiet && sw_word && !prev_atomic;

  // low byte lands in one of four byte lanes
  assign exp_bitwise = {24'd0, instr[7:0]} << ({3'b000, instr[9:8]} * 5'd8);
  assign exp_arith   = {{20{instr[11]}}, instr[11:0]};

  assign slot = {opcode_out, alu_op_out, s_1, s_2, tgt_1, tgt_2, branch_code_out,
                 imm_out, pc_out, is_load, is_store, is_branch, is_post_inc, is_atomic,
                 atomic_step, exc_out, bubble_out};

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_atomic <= 1'b0;
    end else begin
      prev_atomic <= fa_word || sw_word;
    end
  end

  a_reset: assert property (@(posedge clk) $past(rst) |->
    bubble_out && (exc_out == 8'd0) && !is_load && !is_store && !is_branch &&
    !is_post_inc && !is_atomic && (tgt_1 == 5'd0) && (tgt_2 == 5'd0) && !decode_stall)
    else begin
      fail_count++;
      $error("Error at %0t: slot not cleared by reset", $time);
    end

  a_alu_bitwise: assert property (@(posedge clk) disable iff (rst)
    $past(plain && (opc == `DEC_OPC_ALU_IMM) && (aop <= 5'd6)) |->
    imm_out == $past(exp_bitwise))
    else begin
      fail_count++;
      $error("Error at %0t: bitwise imm %h", $time, imm_out);
    end

  a_alu_arith: assert property (@(posedge clk) disable iff (rst)
    $past(plain && (opc == `DEC_OPC_ALU_IMM) && (aop >= 5'd14) && (aop <= 5'd18)) |->
    (imm_out == $past(exp_arith)) && (exc_out == 8'd0))
    else begin
      fail_count++;
      $error("Error at %0t: arith imm %h", $time, imm_out);
    end

  a_post_inc: assert property (@(posedge clk) disable iff (rst)
    $past(plain && ((opc == 5'd3) || (opc == 5'd6) || (opc == 5'd9)) && instr[16] &&
    (instr[15:14] == 2'd2)) |-> is_post_inc && is_load && (tgt_2 == $past(instr[21:17])))
    else begin
      fail_count++;
      $error("Error at %0t: post-increment load decode", $time);
    end

  a_branch_fmt: assert property (@(posedge clk) disable iff (rst)
    $past(plain && ((opc == 5'd13) || (opc == 5'd14)) && (instr[26:22] <= 5'd18)) |->
    is_branch && (s_1 == $past(instr[4:0])) && (tgt_1 == $past(instr[9:5])) &&
    (branch_code_out == $past(instr[26:22])))
    else begin
      fail_count++;
      $error("Error at %0t: branch registers %h %h", $time, s_1, tgt_1);
    end

  a_invalid: assert property (@(posedge clk) disable iff (rst)
    $past(plain && (opc >= `DEC_OPC_INVALID_FIRST) && (opc <= `DEC_OPC_INVALID_LAST)) |->
    (exc_out == `DEC_EXC_INVALID) && !bubble_out && !is_load && !is_store)
    else begin
      fail_count++;
      $error("Error at %0t: invalid opcode exc %h", $time, exc_out);
    end

  a_priv_user: assert property (@(posedge clk) disable iff (rst)
    $past(plain && (opc == `DEC_OPC_PRIV) && !kmode && (aop <= 5'd4)) |->
    (exc_out == `DEC_EXC_PRIV) && !bubble_out)
    else begin
      fail_count++;
      $error("Error at %0t: user privileged exc %h", $time, exc_out);
    end

  a_kill: assert property (@(posedge clk) disable iff (rst)
    $past(!stall && (flush || bubble_in)) |-> bubble_out && (exc_out == 8'd0) &&
    !is_load && !is_store && !is_branch && !is_atomic && (tgt_1 == 5'd0) && (tgt_2 == 5'd0))
    else begin
      fail_count++;
      $error("Error at %0t: killed slot still live", $time);
    end

  a_crack_stall: assert property (@(posedge clk) disable iff (rst)
    (new_fa || new_sw || $past(new_fa) || $past(new_fa, 2) || $past(new_sw)) |-> decode_stall)
    else begin
      fail_count++;
      $error("Error at %0t: decode_stall low during crack", $time);
    end

  a_fa_load: assert property (@(posedge clk) disable iff (rst)
    $past(new_fa) |-> is_atomic && (atomic_step == 2'd0) && is_load && !is_store)
    else begin
      fail_count++;
      $error("Error at %0t: fetch-add load step %0d", $time, atomic_step);
    end

  a_fa_add: assert property (@(posedge clk) disable iff (rst)
    $past(new_fa, 2) |-> is_atomic && (atomic_step == 2'd1) &&
    (alu_op_out == `DEC_ALU_ADD) && (imm_out == 32'd0))
    else begin
      fail_count++;
      $error("Error at %0t: fetch-add add op %0d", $time, alu_op_out);
    end

  a_fa_store: assert property (@(posedge clk) disable iff (rst)
    $past(new_fa, 3) |-> is_atomic && (atomic_step == 2'd2) && is_store && !is_load)
    else begin
      fail_count++;
      $error("Error at %0t: fetch-add store step %0d", $time, atomic_step);
    end

  a_swap_load: assert property (@(posedge clk) disable iff (rst)
    $past(new_sw) |-> is_atomic && (atomic_step == 2'd0) && is_load && !is_store)
    else begin
      fail_count++;
      $error("Error at %0t: swap load step %0d", $time, atomic_step);
    end

  a_swap_store: assert property (@(posedge clk) disable iff (rst)
    $past(new_sw, 2) |-> is_atomic && (atomic_step == 2'd1) && is_store && !is_load)
    else begin
      fail_count++;
      $error("Error at %0t: swap store step %0d", $time, atomic_step);
    end

  // a stalled edge leaves the whole slot untouched
  a_stall_hold: assert property (@(posedge clk)
    ($past(stall) && !$past(rst)) |-> (slot == $past(slot)))
    else begin
      fail_count++;
      $error("Error at %0t: slot changed under stall", $time);
    end

endmodule

bind decode_stage decode_stage_props decode_stage_props_inst (.*);

`default_nettype wire

// File: test/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "decode_params.svh"

module decode_stage_tb;

  logic                  clk;
  logic                  rst;
  logic [`DEC_XLEN-1:0]  instr;
  logic [`DEC_XLEN-1:0]  pc;
  logic                  bubble_in;
  logic [`DEC_EXC_W-1:0] exc_in;
  logic                  stall;
  logic                  flush;
  logic                  kmode;
  logic [`DEC_OPC_W-1:0] opcode_out;
  logic [`DEC_REG_W-1:0] alu_op_out;
  logic [`DEC_REG_W-1:0] s_1;
  logic [`DEC_REG_W-1:0] s_2;
  logic [`DEC_REG_W-1:0] tgt_1;
  logic [`DEC_REG_W-1:0] tgt_2;
  logic [`DEC_XLEN-1:0]  imm_out;
  logic [`DEC_REG_W-1:0] branch_code_out;
  logic [`DEC_XLEN-1:0]  pc_out;
  logic                  is_load;
  logic                  is_store;
  logic                  is_branch;
  logic                  is_post_inc;
  logic                  is_atomic;
  decode_pkg::uop_step_t atomic_step;
  logic [`DEC_EXC_W-1:0] exc_out;
  logic                  bubble_out;
  logic                  decode_stall;

  integer seed;
  int     tests_run;
  int     tests_failed;
  int     timeouts;
  int     mark;

  decode_stage decode_stage_inst (.*);

  always #20 clk = ~clk;

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_word(input logic [`DEC_XLEN-1:0] word);
    instr = word;
    pc    = pc + 32'd4;
    next_cycle();
  endtask

  function automatic int error_total();
    return decode_stage_inst.decode_stage_props_inst.fail_count + timeouts;
  endfunction

  // two idle slots so the checks on the last word get evaluated
  task automatic close_test(input string name);
    int errs;
    drive_word(32'd0);
    drive_word(32'd0);
    errs = error_total() - mark;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs);
    end
    mark = error_total();
  endtask

  // frontend holds the atomic word for its micro-ops, then moves on
  task automatic run_crack(input logic [`DEC_XLEN-1:0] word, input int slots);
    int n;
    instr = word;
    repeat (slots) next_cycle();
    instr = 32'd0;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (decode_stall && (n < 8));
    if (decode_stall) begin
      timeouts++;
      $display("timeout at %0t: decode_stall stuck high after a crack", $time);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [4:0]  op;
    seed         = 32'hba71c14c;
    clk          = 1'b0;
    rst          = 1'b1;
    instr        = 32'd0;
    pc           = 32'd0;
    bubble_in    = 1'b0;
    exc_in       = 8'd0;
    stall        = 1'b0;
    flush        = 1'b0;
    kmode        = 1'b1;
    tests_run    = 0;
    tests_failed = 0;
    timeouts     = 0;
    mark         = 0;
    repeat (2) next_cycle();
    rst = 1'b0;
    close_test("reset values");

    // bitwise then arithmetic immediates
    for (int i = 0; i < 8; i++) begin
      r  = $random(seed);
      op = (r[2:0] == 3'd7) ? 5'd4 : {2'b00, r[2:0]};
      drive_word({`DEC_OPC_ALU_IMM, r[26:17], op, r[11:0]});
      r  = $random(seed);
      op = 5'd14 + {3'b000, r[14:13]};
      drive_word({`DEC_OPC_ALU_IMM, r[26:17], op, r[11:0]});
    end
    close_test("alu immediates");

    // absolute loads with post-increment, then conditional branches
    for (op = 5'd3; op <= 5'd9; op = op + 5'd3) begin
      r = $random(seed);
      drive_word({op, r[26:17], 1'b1, 2'd2, r[13:0]});
    end
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      drive_word({5'd13 + {4'b0000, r[31]}, 1'b0, r[29:26], r[21:0]});
    end
    close_test("memory and branch operands");

    for (op = `DEC_OPC_INVALID_FIRST; op <= `DEC_OPC_INVALID_LAST; op = op + 5'd1) begin
      r = $random(seed);
      drive_word({op, r[26:0]});
    end
    kmode = 1'b0;
    r = $random(seed);
    drive_word({`DEC_OPC_PRIV, r[26:17], 5'd2, r[11:0]});
    kmode = 1'b1;
    flush = 1'b1;
    drive_word({`DEC_OPC_INVALID_FIRST, r[26:0]});
    flush     = 1'b0;
    bubble_in = 1'b1;
    drive_word({5'd3, r[26:17], 1'b1, 2'd2, r[13:0]});
    bubble_in = 1'b0;
    close_test("exceptions and kill");

    r = $random(seed);
    run_crack({`DEC_OPC_FADD_FIRST, r[26:0]}, 3);
    r = $random(seed);
    run_crack({`DEC_OPC_SWAP_FIRST + 5'd1, r[26:0]}, 2);
    close_test("atomic cracking");

    r = $random(seed);
    drive_word({`DEC_OPC_ALU_IMM, r[26:17], 5'd2, r[11:0]});
    stall = 1'b1;
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      drive_word({`DEC_OPC_ALU_IMM, r[26:0]});
    end
    stall = 1'b0;
    close_test("stall hold");

    $display("%0d tests run, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/instr_classify.sv
rtl/operand_select.sv
rtl/atomic_cracker.sv
rtl/decode_stage.sv
test/decode_stage_props.sv
test/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	@out=$$($(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
